//--- verif/mxu_vectors.txt
# W data_type w00 w01 w02 w10 w11 w12 w20 w21 w22    (data_type 0 int8, 1 int4 pair)
# X in0 in1 in2 exp0 exp1 exp2                        (all lanes in hex)

# int8 batch, negative values and overflow
W 0 01 02 03 FF 00 04 10 20 7F
X 01 01 01 06 03 AF
X 02 03 04 14 0E 7C
X FF FF FF FA FD 51
X 80 00 00 80 80 00
X 00 00 00 00 00 00
X 7F 81 05 90 95 8B
X 10 F0 03 F9 FC 7D

# int4 pair batch, each nibble wraps on its own
W 1 11 23 F2 7F 88 01 34 C5 66
X 11 11 11 26 F8 5F
X 12 34 5F 2C FD 56
X F0 0F 88 7D 90 DB
X 70 07 00 75 18 53
X 00 00 00 00 00 00
X 99 AB 7C 62 FB D3

# back to int8 with new weights
W 0 02 00 00 00 03 00 01 01 01
X 05 06 07 0A 12 12
X 40 40 40 80 C0 C0
X FE 80 01 FC 80 7F
X 11 22 33 22 66 66

//--- compile.f
common/mxu_pkg.sv
hw/lane_delay.sv
hw/weight_bank.sv
mxu/mxu_cell.sv
mxu/mxu_core.sv
hw/mxu_top.sv
verif/mxu_tb.sv

//--- verif/mxu_tb.sv
// matrix unit testbench that replays weight and vector records from a file and checks results

`timescale 1ns/1ps

module mxu_tb;

   // one line of the vector file holds a weight load or an input with its result
   typedef struct packed {
      logic                 is_load;
      mxu_pkg::precision_t  prec;
      mxu_pkg::weight_mat_t weights;
      mxu_pkg::in_vec_t     vec;
      mxu_pkg::out_vec_t    expected;
   } record_t;

   logic                 clk         = 1'b0;
   logic                 reset       = 1'b1;
   logic                 enable      = 1'b0;
   mxu_pkg::precision_t  data_type   = mxu_pkg::prec_int8;
   logic                 weight_load = 1'b0;
   mxu_pkg::weight_mat_t weights_in  = '0;
   logic                 in_valid    = 1'b0;
   mxu_pkg::in_vec_t     in_vec      = '0;
   logic                 out_valid;
   mxu_pkg::out_vec_t    out_vec;

   record_t           records [$];
   mxu_pkg::out_vec_t exp_q [$];      // results still owed by the DUT
   int                edge_q [$];     // enabled edge on which each one was accepted
   int                enabled_edges = 0;
   int                errors        = 0;
   int                checks        = 0;
   int                cycle_count   = 0;
   int                cycle_limit   = 100;
   int                n_vectors     = 0;
   int                n_loads       = 0;

   mxu_top i_dut (
      .clk         (clk),
      .reset       (reset),
      .enable      (enable),
      .data_type   (data_type),
      .weight_load (weight_load),
      .weights_in  (weights_in),
      .in_valid    (in_valid),
      .in_vec      (in_vec),
      .out_valid   (out_valid),
      .out_vec     (out_vec)
   );

   always #50 clk = ~clk;

   // watchdog sized from the number of records in the file
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout after %0d cycles, the DUT stopped producing results", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   // ==========================================================================
   // checking
   // ==========================================================================

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // sampled on the falling edge half a period after the outputs settle
   task automatic watch_outputs();
      mxu_pkg::out_vec_t exp_vec;
      int                accepted;
      if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("out_valid at %0t with no result pending", $time);
         end else begin
            exp_vec  = exp_q.pop_front();
            accepted = edge_q.pop_front();
            for (int i = 0; i < mxu_pkg::rows; i++) begin
               check_value($sformatf("out_vec[%0d]", i), out_vec[i], exp_vec[i]);
            end
            check_value("latency", enabled_edges - accepted, mxu_pkg::latency);
         end
      end else if (out_valid !== 1'b0) begin
         errors++;
         $display("out_valid is unknown at %0t", $time);
      end
   endtask

   // outputs are looked at before the caller drives new inputs
   task automatic next_cycle();
      @(negedge clk);
      if (enable) begin
         enabled_edges++;     // the rising edge just passed was an enabled one
      end
      watch_outputs();
   endtask

   // ==========================================================================
   // stimulus
   // ==========================================================================

   task automatic read_vectors();
      int            fd;
      int            n;
      logic [31:0]   v;
      string         tok;
      string         line;
      record_t       rec;
      bit            done;
      fd = $fopen("verif/mxu_vectors.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open verif/mxu_vectors.txt");
      end else begin
         done = 1'b0;
         while (!done) begin
            n = $fscanf(fd, "%s", tok);
            rec = '0;
            if (n != 1) begin
               done = 1'b1;
            end else if (tok.substr(0, 0) == "#") begin
               n = $fgets(line, fd);               // rest of a comment line
            end else if (tok == "W") begin
               n = $fscanf(fd, "%h", v);
               rec.is_load = 1'b1;
               rec.prec    = mxu_pkg::precision_t'(v[0]);
               for (int i = 0; i < mxu_pkg::rows; i++) begin
                  for (int j = 0; j < mxu_pkg::cols; j++) begin
                     n = $fscanf(fd, "%h", v);
                     rec.weights[i][j] = v[7:0];
                  end
               end
               records.push_back(rec);
               n_loads++;
            end else if (tok == "X") begin
               for (int j = 0; j < mxu_pkg::cols; j++) begin
                  n = $fscanf(fd, "%h", v);
                  rec.vec[j] = v[7:0];
               end
               for (int i = 0; i < mxu_pkg::rows; i++) begin
                  n = $fscanf(fd, "%h", v);
                  rec.expected[i] = v[7:0];
               end
               records.push_back(rec);
               n_vectors++;
            end else begin
               errors++;
               $display("unknown record type %s in the vector file", tok);
               done = 1'b1;
            end
         end
         $fclose(fd);
      end
   endtask

   // waits for every result in flight and gives up after one pipeline length
   task automatic drain();
      for (int k = 0; k < mxu_pkg::latency + 3 && exp_q.size() != 0; k++) begin
         next_cycle();
         enable   = 1'b1;
         in_valid = 1'b0;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d results never came out of the DUT", exp_q.size());
         exp_q.delete();
         edge_q.delete();
      end
   endtask

   // precision settles one edge before the load strobe
   task automatic load_weights(input record_t rec);
      drain();
      next_cycle();
      enable    = 1'b1;
      in_valid  = 1'b0;
      data_type = rec.prec;
      next_cycle();
      weight_load = 1'b1;
      weights_in  = rec.weights;
      next_cycle();
      weight_load = 1'b0;
      weights_in  = '0;
   endtask

   task automatic send_vector(input record_t rec, input bit use_gaps);
      int gap;
      gap = use_gaps ? int'($urandom % 4) : 0;
      repeat (gap) begin
         next_cycle();
         enable   = 1'b0;
         in_valid = 1'b1;     // must be ignored during a stall
         in_vec   = rec.vec;
      end
      next_cycle();
      enable   = 1'b1;
      in_valid = 1'b1;
      in_vec   = rec.vec;
      exp_q.push_back(rec.expected);
      edge_q.push_back(enabled_edges + 1);
   endtask

   task automatic run_pass(input bit use_gaps);
      foreach (records[r]) begin
         if (records[r].is_load) begin
            load_weights(records[r]);
         end else begin
            send_vector(records[r], use_gaps);
         end
      end
      drain();
   endtask

   // ==========================================================================
   // test sequence
   // ==========================================================================

   initial begin
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(71));
      read_vectors();
      cycle_limit = 2 * (n_vectors + n_loads) * 4 + 100;    // two passes over the file

      repeat (5) @(posedge clk);
      @(negedge clk);
      reset  = 1'b0;
      enable = 1'b1;

      // outputs stay clear until the first vector
      for (int k = 0; k < 3; k++) begin
         next_cycle();
         check_value("out_valid", out_valid, 1'b0);
         check_value("out_vec", out_vec, '0);
      end

      run_pass(1'b0);     // enable held high with one vector per cycle
      run_pass(1'b1);     // same records with random stalls

      repeat (3) next_cycle();
      $display("mxu_tb finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- hw/mxu_top.sv
// matrix unit top level with input skew, systolic core, output deskew and result valid tracking

`timescale 1ns/1ps

module mxu_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,       // stalls the whole pipeline when low
   input  mxu_pkg::precision_t  data_type,
   input  logic                 weight_load,
   input  mxu_pkg::weight_mat_t weights_in,
   input  logic                 in_valid,
   input  mxu_pkg::in_vec_t     in_vec,
   output logic                 out_valid,
   output mxu_pkg::out_vec_t    out_vec
);

   mxu_pkg::weight_mat_t           weights;
   mxu_pkg::in_vec_t               skewed;      // lane j delayed by j
   mxu_pkg::out_vec_t              core_sum;    // row i late by i
   mxu_pkg::out_vec_t              aligned;     // all rows from the same vector
   logic [mxu_pkg::latency-1:0]    valid_sr;
   logic                           out_valid_q;
   mxu_pkg::count_t                inflight;

   // =========================================================================
   // weights and input skew
   // =========================================================================

   weight_bank u_weights (
      .clk         (clk),
      .reset       (reset),
      .weight_load (weight_load),
      .weights_in  (weights_in),
      .weights     (weights)
   );

   for (genvar j = 0; j < mxu_pkg::cols; j++) begin : g_skew
      lane_delay #(.depth(j)) u_skew (
         .clk (clk), .reset (reset), .enable (enable),
         .d   (in_vec[j]),
         .q   (skewed[j])
      );
   end

   // =========================================================================
   // array and output deskew
   // =========================================================================

   mxu_core u_core (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .data_type (data_type),
      .weights   (weights),
      .data_top  (skewed),
      .row_sum   (core_sum)
   );

   for (genvar i = 0; i < mxu_pkg::rows; i++) begin : g_deskew
      lane_delay #(.depth(mxu_pkg::rows - 1 - i)) u_deskew (
         .clk (clk), .reset (reset), .enable (enable),
         .d   (core_sum[i]),
         .q   (aligned[i])
      );
   end

   // =========================================================================
   // valid pipeline and output register
   // =========================================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_sr    <= '0;
         out_valid_q <= 1'b0;
         out_vec     <= '0;
         inflight    <= '0;
      end else if (enable) begin
         valid_sr    <= {valid_sr[mxu_pkg::latency-2:0], in_valid};
         out_valid_q <= valid_sr[mxu_pkg::latency-1];
         out_vec     <= aligned;                        // result of the oldest item
         inflight    <= inflight + mxu_pkg::count_t'(in_valid)
                        - mxu_pkg::count_t'(valid_sr[mxu_pkg::latency-1]);
      end
   end

   assign out_valid = out_valid_q & enable;   // no result is offered during a stall

   // =========================================================================
   // protocol checks
   // =========================================================================

   // cells of one item read data_type on different edges
   a_type_stable: assert property (@(posedge clk) disable iff (reset)
      (inflight != '0) |-> $stable(data_type))
      else $error("data_type changed with items in flight");

   a_type_at_load: assert property (@(posedge clk) disable iff (reset)
      weight_load |-> $stable(data_type))
      else $error("data_type changed together with weight_load");

   // new weights reach the cells one edge late, so nothing may be in the array
   a_load_idle: assert property (@(posedge clk) disable iff (reset)
      weight_load |-> (inflight == '0) && !(enable && in_valid))
      else $error("weight_load while the array is busy");

endmodule

//--- mxu/mxu_core.sv
// matrix unit core: rows by cols grid of MAC cells, data flows down and sums flow right

`timescale 1ns/1ps

module mxu_core (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  mxu_pkg::precision_t  data_type,
   input  mxu_pkg::weight_mat_t weights,
   input  mxu_pkg::in_vec_t     data_top,     // already skewed, lane j is j cycles late
   output mxu_pkg::out_vec_t    row_sum       // row i lands i cycles after row 0
);

   // data_link[i][j] enters cell (i,j); the extra bottom row is what leaves the array
   mxu_pkg::lane_u data_link [mxu_pkg::rows+1][mxu_pkg::cols];

   // sum_link[i][j] is the partial sum entering cell (i,j)
   mxu_pkg::lane_u sum_link [mxu_pkg::rows][mxu_pkg::cols+1];

   // =========================================================================
   // array edges
   // =========================================================================

   for (genvar j = 0; j < mxu_pkg::cols; j++) begin : g_top
      assign data_link[0][j] = data_top[j];
   end

   for (genvar i = 0; i < mxu_pkg::rows; i++) begin : g_edge
      assign sum_link[i][0] = '0;                        // no sum enters from the left
      assign row_sum[i]     = sum_link[i][mxu_pkg::cols]; // last column drives the row
   end

   // =========================================================================
   // cell grid
   // =========================================================================

   for (genvar i = 0; i < mxu_pkg::rows; i++) begin : g_row
      for (genvar j = 0; j < mxu_pkg::cols; j++) begin : g_col
         mxu_cell #(
            .has_psum_in (j != 0)
         ) u_cell (
            .clk       (clk),
            .reset     (reset),
            .enable    (enable),
            .data_type (data_type),
            .data_in   (data_link[i][j]),
            .weight    (weights[i][j]),
            .psum_in   (sum_link[i][j]),
            .data_out  (data_link[i+1][j]),
            .psum_out  (sum_link[i][j+1])
         );
      end
   end

   // the word leaving the bottom row is the one that entered at the top rows enabled
   // edges earlier, once enable has stayed high long enough to flush the reset zeros
   for (genvar j = 0; j < mxu_pkg::cols; j++) begin : g_chk
      a_column_pass: assert property (@(posedge clk) disable iff (reset)
         (enable && $past(enable, 1) && $past(enable, 2) && $past(enable, 3)
          && !$past(reset, mxu_pkg::rows))
         |-> data_link[mxu_pkg::rows][j] == $past(data_top[j], mxu_pkg::rows))
         else $error("column %0d lost data on its way down", j);
   end

endmodule

//--- mxu/mxu_cell.sv
// systolic MAC cell: multiply by a stationary weight, add the partial sum, forward data down

`timescale 1ns/1ps

module mxu_cell #(
   parameter bit has_psum_in = 1'b1            // 0 in the first column, which only multiplies
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                enable,
   input  mxu_pkg::precision_t data_type,
   input  mxu_pkg::lane_u      data_in,         // from the cell above
   input  mxu_pkg::lane_u      weight,
   input  mxu_pkg::lane_u      psum_in,         // from the cell on the left
   output mxu_pkg::lane_u      data_out,
   output mxu_pkg::lane_u      psum_out
);

   mxu_pkg::lane_u psum_eff;
   mxu_pkg::lane_u mac;

   // =========================================================================
   // lane arithmetic
   // =========================================================================

   // first column has nothing on its left
   assign psum_eff = has_psum_in ? psum_in : '0;

   // each result is sized by the lane it lands in, so it wraps there
   always_comb begin
      mac = '0;
      if (data_type == mxu_pkg::prec_int4x2) begin
         // two separate 4-bit MACs, nothing carries from lo into hi
         mac.pair.hi = weight.pair.hi * data_in.pair.hi + psum_eff.pair.hi;
         mac.pair.lo = weight.pair.lo * data_in.pair.lo + psum_eff.pair.lo;
      end else begin
         mac.full = weight.full * data_in.full + psum_eff.full;   // modulo 256
      end
   end

   // =========================================================================
   // pipeline registers
   // =========================================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         data_out <= '0;
         psum_out <= '0;
      end else if (enable) begin
         data_out <= data_in;       // same word moves one row down
         psum_out <= mac;           // sum moves one column right
      end
   end

endmodule

//--- hw/weight_bank.sv
// weight bank: holds the stationary weight matrix, captured on a load strobe

`timescale 1ns/1ps

module weight_bank (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 weight_load,   // capture strobe
   input  mxu_pkg::weight_mat_t weights_in,
   output mxu_pkg::weight_mat_t weights        // to every cell of the core
);

   // =========================================================================
   // storage
   // =========================================================================

   // loads ignore enable so the matrix can be set up while the array is stalled
   always_ff @(posedge clk) begin
      if (reset) begin
         weights <= '0;
      end else if (weight_load) begin
         weights <= weights_in;          // visible one cycle after the strobe
      end
   end

   // =========================================================================
   // checks
   // =========================================================================

   // an unknown bit here would spread into every later result of its row
   a_load_known: assert property (@(posedge clk) disable iff (reset)
      weight_load |-> !$isunknown(weights_in))
      else $error("weight load with unknown bits in the matrix");

endmodule

//--- hw/lane_delay.sv
// lane delay: enabled register chain that holds one lane back by a fixed number of cycles

`timescale 1ns/1ps

module lane_delay #(
   parameter int depth = 1                    // 0 gives a plain wire
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           enable,
   input  mxu_pkg::lane_u d,
   output mxu_pkg::lane_u q
);

   if (depth == 0) begin : g_wire
      assign q = d;
   end else begin : g_chain
      mxu_pkg::lane_u stage [depth];

      always_ff @(posedge clk) begin
         if (reset) begin
            for (int k = 0; k < depth; k++) begin
               stage[k] <= '0;
            end
         end else if (enable) begin
            stage[0] <= d;
            for (int k = 1; k < depth; k++) begin
               stage[k] <= stage[k-1];    // shift one place per enabled edge
            end
         end
      end

      assign q = stage[depth-1];
   end

endmodule

//--- common/mxu_pkg.sv
// matrix unit package: array sizes, lane views, precision select and vector types

package mxu_pkg;

   // =========================================================================
   // array geometry
   // =========================================================================

   localparam int rows       = 3;              // weight rows, result lanes
   localparam int cols       = 3;              // input lanes, array columns
   localparam int lane_width = 8;
   localparam int nib_width  = lane_width / 2;

   // enabled edges from accepting a vector to out_vec holding its result
   localparam int latency = rows + cols - 1;

   // items tracked by the in-flight counter in the top level
   localparam int cnt_width = $clog2(latency + 1);

   typedef logic [cnt_width-1:0] count_t;

   // =========================================================================
   // lane encodings
   // =========================================================================

   // how every 8-bit word in the array is interpreted
   typedef enum logic {
      prec_int8   = 1'b0,                      // one signed byte per lane
      prec_int4x2 = 1'b1                       // two signed nibbles per lane
   } precision_t;

   // two independent signed nibbles, hi sits in bits 7:4
   typedef struct packed {
      logic signed [nib_width-1:0] hi;
      logic signed [nib_width-1:0] lo;
   } nib_pair_t;

   // one lane word, read as a byte or as a nibble pair
   typedef union packed {
      logic signed [lane_width-1:0] full;
      nib_pair_t                    pair;
   } lane_u;

   // =========================================================================
   // vectors and matrices
   // =========================================================================

   typedef lane_u [cols-1:0] in_vec_t;         // lane j feeds column j
   typedef lane_u [rows-1:0] out_vec_t;        // lane i is the dot product of row i

   // element [i][j] multiplies input lane j into result lane i
   typedef lane_u [rows-1:0][cols-1:0] weight_mat_t;

endpackage
